//--- common/ex_pkg.sv
package ex_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 6;  // GPRs plus the FP/SPR space
  localparam int NUM_SPR    = 4;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////
  // Operators
  //////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    // Branch comparisons
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL_MUL,    // Low word
    MUL_MULH,   // High word, signed, two cycles
    MUL_DOT16   // Two 16-bit lanes plus accumulator
  } mult_op_e;

  // Load-to-SPR tag with idx above en
  typedef struct packed {
    logic [$clog2(NUM_SPR)-1:0] idx;
    logic                       en;
  } tospr_t;

endpackage

//--- common/issue_if.sv
`timescale 1ns/1ns

// Operands and operator handed from the stage to one functional unit
interface issue_if #(
  parameter type op_t = logic
);

  logic          en;
  op_t           operator;
  ex_pkg::word_t op_a;
  ex_pkg::word_t op_b;
  ex_pkg::word_t op_c;  // Accumulator or jump target

  modport stage (
    output en, operator, op_a, op_b, op_c
  );

  modport unit (
    input en, operator, op_a, op_b, op_c
  );

endinterface

//--- hw/ex_alu.sv
`timescale 1ns/1ns

module ex_alu (
  input  logic          clk,
  input  logic          rst_n,
  issue_if.unit         issue,
  output ex_pkg::word_t result_o,
  output logic          cmp_result_o
);

  logic [4:0] shamt;
  logic       is_eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = issue.op_b[4:0];
  assign is_eq = (issue.op_a == issue.op_b);
  assign lt_s  = ($signed(issue.op_a) < $signed(issue.op_b));
  assign lt_u  = (issue.op_a < issue.op_b);

  // Branch condition is low for all non-branch operators
  always_comb begin
    unique case (issue.operator)
      ex_pkg::ALU_EQ:  cmp_result_o = is_eq;
      ex_pkg::ALU_NE:  cmp_result_o = ~is_eq;
      ex_pkg::ALU_LT:  cmp_result_o = lt_s;
      ex_pkg::ALU_GE:  cmp_result_o = ~lt_s;
      ex_pkg::ALU_LTU: cmp_result_o = lt_u;
      ex_pkg::ALU_GEU: cmp_result_o = ~lt_u;
      default:         cmp_result_o = 1'b0;
    endcase
  end

  always_comb begin
    unique case (issue.operator)
      ex_pkg::ALU_ADD:  result_o = issue.op_a + issue.op_b;
      ex_pkg::ALU_SUB:  result_o = issue.op_a - issue.op_b;
      ex_pkg::ALU_AND:  result_o = issue.op_a & issue.op_b;
      ex_pkg::ALU_OR:   result_o = issue.op_a | issue.op_b;
      ex_pkg::ALU_XOR:  result_o = issue.op_a ^ issue.op_b;
      ex_pkg::ALU_SLL:  result_o = issue.op_a << shamt;
      ex_pkg::ALU_SRL:  result_o = issue.op_a >> shamt;
      ex_pkg::ALU_SRA:  result_o = ex_pkg::word_t'($signed(issue.op_a) >>> shamt);
      ex_pkg::ALU_SLT:  result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
      ex_pkg::ALU_SLTU: result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
      default:          result_o = {{(ex_pkg::XLEN-1){1'b0}}, cmp_result_o};  // Branches
    endcase
  end

  // The decoder must never issue a garbage operator
  operator_known_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    issue.en |-> !$isunknown(issue.operator)
  );

endmodule

//--- hw/ex_mult.sv
`timescale 1ns/1ns

module ex_mult (
  input  logic          clk,
  input  logic          rst_n,
  issue_if.unit         issue,
  input  logic          ex_ready_i,
  output ex_pkg::word_t result_o,
  output logic          ready_o,
  output logic          multicycle_o
);

  typedef enum logic {
    MULT_IDLE,
    MULT_HIGH  // Upper word registered and presented
  } mult_state_e;

  mult_state_e        state_q;
  mult_state_e        state_d;
  logic signed [63:0] prod_full;
  logic signed [31:0] dot_hi;
  logic signed [31:0] dot_lo;
  ex_pkg::word_t      dot_res;
  ex_pkg::word_t      mulh_q;

  // One 32x32 signed array since the low word is sign agnostic
  assign prod_full = $signed(issue.op_a) * $signed(issue.op_b);

  assign dot_hi  = $signed(issue.op_a[31:16]) * $signed(issue.op_b[31:16]);
  assign dot_lo  = $signed(issue.op_a[15:0]) * $signed(issue.op_b[15:0]);
  assign dot_res = issue.op_c + ex_pkg::word_t'(dot_hi) + ex_pkg::word_t'(dot_lo);

  always_comb begin
    state_d      = state_q;
    ready_o      = 1'b1;
    multicycle_o = 1'b0;
    case (state_q)
      MULT_IDLE: begin
        if (issue.en && issue.operator == ex_pkg::MUL_MULH) begin
          ready_o = 1'b0;  // Stall for the high word
          state_d = MULT_HIGH;
        end
      end
      default: begin
        multicycle_o = 1'b1;
        if (ex_ready_i) begin
          state_d = MULT_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == MULT_IDLE && state_d == MULT_HIGH) begin
      mulh_q <= prod_full[63:32];
    end
  end

  always_comb begin
    if (state_q == MULT_HIGH) begin
      result_o = mulh_q;
    end else if (issue.operator == ex_pkg::MUL_DOT16) begin
      result_o = dot_res;
    end else begin
      result_o = prod_full[ex_pkg::XLEN-1:0];
    end
  end

  // At most one stall cycle per MULH
  single_stall_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    !ready_o |=> ready_o
  );

endmodule

//--- hw/spr_rnn.sv
`timescale 1ns/1ns

module spr_rnn (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               spr_we_i,
  input  logic [$clog2(ex_pkg::NUM_SPR)-1:0] spr_idx_i,
  input  ex_pkg::word_t                      lsu_rdata_i,
  input  ex_pkg::tospr_t                     tospr_ex_i,
  input  ex_pkg::word_t                      dot_op_a_i,
  output ex_pkg::word_t                      dot_op_a_o
);

  ex_pkg::word_t spr_q [ex_pkg::NUM_SPR];

  // Load data lands in the SPR during the WB cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < ex_pkg::NUM_SPR; i++) begin
        spr_q[i] <= '0;
      end
    end else if (spr_we_i) begin
      spr_q[spr_idx_i] <= lsu_rdata_i;
    end
  end

  // Dot product operand a from the tagged SPR
  assign dot_op_a_o = tospr_ex_i.en ? spr_q[tospr_ex_i.idx] : dot_op_a_i;

endmodule

//--- hw/ex_wb_reg.sv
`timescale 1ns/1ns

module ex_wb_reg (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               ex_valid_i,
  input  logic                               wb_ready_i,
  input  logic                               regfile_we_i,
  input  logic                               lsu_err_i,
  input  ex_pkg::reg_addr_t                  regfile_waddr_i,
  input  ex_pkg::tospr_t                     tospr_ex_i,
  input  ex_pkg::word_t                      mult_result_i,
  input  ex_pkg::word_t                      lsu_rdata_i,
  output logic                               regfile_we_wb_o,
  output ex_pkg::reg_addr_t                  regfile_waddr_wb_o,
  output ex_pkg::word_t                      regfile_wdata_wb_o,
  output logic                               spr_we_o,
  output logic [$clog2(ex_pkg::NUM_SPR)-1:0] spr_idx_o
);

  logic              we_q;
  ex_pkg::reg_addr_t waddr_q;
  ex_pkg::tospr_t    tospr_q;
  ex_pkg::word_t     mult_result_q;  // Free running copy one cycle old

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      tospr_q <= '0;
    end else if (ex_valid_i) begin
      we_q    <= regfile_we_i & ~lsu_err_i;  // Bus error kills the write
      tospr_q <= tospr_ex_i;
    end else if (wb_ready_i) begin
      we_q    <= 1'b0;  // Nothing new so the slot flushes
    end
  end

  always_ff @(posedge clk) begin
    mult_result_q <= mult_result_i;
    if (ex_valid_i) begin
      waddr_q <= regfile_waddr_i;
    end
  end

  // Load port mux
  assign regfile_we_wb_o    = we_q;
  assign regfile_waddr_wb_o = waddr_q;
  assign regfile_wdata_wb_o = tospr_q.en ? mult_result_q : lsu_rdata_i;
  assign spr_we_o           = we_q & tospr_q.en;
  assign spr_idx_o          = tospr_q.idx;

endmodule

//--- hw/ex_stage.sv
`timescale 1ns/1ns

module ex_stage (
  input  logic              clk,
  input  logic              rst_n,
  // ALU issue
  input  logic              alu_en_i,
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::word_t     alu_operand_a_i,
  input  ex_pkg::word_t     alu_operand_b_i,
  input  ex_pkg::word_t     alu_operand_c_i,
  // Multiplier issue
  input  logic              mult_en_i,
  input  ex_pkg::mult_op_e  mult_operator_i,
  input  ex_pkg::word_t     mult_operand_a_i,
  input  ex_pkg::word_t     mult_operand_b_i,
  input  ex_pkg::word_t     mult_operand_c_i,
  // Load path
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  ex_pkg::tospr_t    lsu_tospr_ex_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  // CSR and branch
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              branch_in_ex_i,
  // Register writes
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              wb_ready_i,
  // Forwarding to ID
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::word_t     regfile_alu_wdata_fw_o,
  // Load write port
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::word_t     regfile_wdata_wb_o,
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,
  output logic              mult_multicycle_o,
  output logic              compute_load_vliw_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  ex_pkg::word_t                      alu_result;
  logic                               alu_cmp_result;
  ex_pkg::word_t                      mult_result;
  logic                               mult_ready;
  ex_pkg::word_t                      dot_op_a;
  logic                               spr_we;
  logic [$clog2(ex_pkg::NUM_SPR)-1:0] spr_idx;

  issue_if #(.op_t(ex_pkg::alu_op_e))  alu_if ();
  issue_if #(.op_t(ex_pkg::mult_op_e)) mult_if ();

  //////////////////////////////
  // ALU
  //////////////////////////////

  assign alu_if.en       = alu_en_i;
  assign alu_if.operator = alu_operator_i;
  assign alu_if.op_a     = alu_operand_a_i;
  assign alu_if.op_b     = alu_operand_b_i;
  assign alu_if.op_c     = alu_operand_c_i;

  ex_alu u_alu (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue        (alu_if.unit),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_if.op_c;  // Target computed in ID

  //////////////////////////////
  // Multiplier and SPRs
  //////////////////////////////

  spr_rnn u_spr (
    .clk         (clk),
    .rst_n       (rst_n),
    .spr_we_i    (spr_we),
    .spr_idx_i   (spr_idx),
    .lsu_rdata_i (lsu_rdata_i),
    .tospr_ex_i  (lsu_tospr_ex_i),
    .dot_op_a_i  (mult_operand_a_i),
    .dot_op_a_o  (dot_op_a)
  );

  assign mult_if.en       = mult_en_i;
  assign mult_if.operator = mult_operator_i;
  assign mult_if.op_a     = dot_op_a;
  assign mult_if.op_b     = mult_operand_b_i;
  assign mult_if.op_c     = mult_operand_c_i;

  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue        (mult_if.unit),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  //////////////////////////////
  // Write ports
  //////////////////////////////

  assign compute_load_vliw_o = alu_en_i & mult_en_i;

  always_comb begin
    regfile_alu_we_fw_o    = regfile_alu_we_i;
    regfile_alu_waddr_fw_o = regfile_alu_waddr_i;
    if (compute_load_vliw_o) begin
      regfile_alu_wdata_fw_o = alu_result;  // Multiplier result goes via WB
    end else if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result;
    end else begin
      regfile_alu_wdata_fw_o = alu_result;
    end
  end

  ex_wb_reg u_ex_wb (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_valid_i         (ex_valid_o),
    .wb_ready_i         (wb_ready_i),
    .regfile_we_i       (regfile_we_i),
    .lsu_err_i          (lsu_err_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .tospr_ex_i         (lsu_tospr_ex_i),
    .mult_result_i      (mult_result),
    .lsu_rdata_i        (lsu_rdata_i),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o),
    .regfile_wdata_wb_o (regfile_wdata_wb_o),
    .spr_we_o           (spr_we),
    .spr_idx_o          (spr_idx)
  );

  // Branches resolve here and never need WB
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i)
                      & mult_ready & lsu_ready_ex_i & wb_ready_i;

endmodule

//--- testbench/tb_ex_stage.sv
`timescale 1ns/1ns

module tb_ex_stage;

  localparam int HALF_PERIOD = 10;
  localparam int SAMPLE_DLY  = 8;   // Just ahead of the rising edge
  localparam int WAIT_LIMIT  = 10;
  localparam int NUM_RAND    = 8;

  typedef struct packed {
    ex_pkg::alu_op_e op;
    ex_pkg::word_t   a;
    ex_pkg::word_t   b;
    ex_pkg::word_t   res;
    logic            br;
  } alu_row_t;

  logic              clk;
  logic              rst_n;
  logic              alu_en_i, mult_en_i, lsu_en_i, lsu_ready_ex_i, lsu_err_i;
  logic              csr_access_i, branch_in_ex_i, wb_ready_i;
  logic              regfile_alu_we_i, regfile_we_i;
  ex_pkg::alu_op_e   alu_operator_i;
  ex_pkg::mult_op_e  mult_operator_i;
  ex_pkg::word_t     alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  ex_pkg::word_t     mult_operand_a_i, mult_operand_b_i, mult_operand_c_i;
  ex_pkg::word_t     lsu_rdata_i, csr_rdata_i;
  ex_pkg::tospr_t    lsu_tospr_ex_i;
  ex_pkg::reg_addr_t regfile_alu_waddr_i, regfile_waddr_i;
  logic              regfile_alu_we_fw_o, regfile_we_wb_o, branch_decision_o;
  logic              mult_multicycle_o, compute_load_vliw_o, ex_ready_o, ex_valid_o;
  ex_pkg::reg_addr_t regfile_alu_waddr_fw_o, regfile_waddr_wb_o;
  ex_pkg::word_t     regfile_alu_wdata_fw_o, regfile_wdata_wb_o, jump_target_o;

  int          errors    = 0;
  int          timeouts  = 0;
  logic [31:0] rng_state = 32'd71;

  // Operator, operand a, operand b, result, branch taken
  alu_row_t alu_tab [16] = '{
    '{ex_pkg::ALU_ADD,  32'h0000_1234, 32'h0000_0fff, 32'h0000_2233, 1'b0},
    '{ex_pkg::ALU_SUB,  32'h0000_0005, 32'h0000_0007, 32'hffff_fffe, 1'b0},
    '{ex_pkg::ALU_AND,  32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200, 1'b0},
    '{ex_pkg::ALU_OR,   32'hf000_000f, 32'h0f00_00f0, 32'hff00_00ff, 1'b0},
    '{ex_pkg::ALU_XOR,  32'haaaa_5555, 32'hffff_0000, 32'h5555_5555, 1'b0},
    '{ex_pkg::ALU_SLL,  32'h0000_0001, 32'h0000_0024, 32'h0000_0010, 1'b0},  // shamt is 4
    '{ex_pkg::ALU_SRL,  32'h8000_0000, 32'h0000_0004, 32'h0800_0000, 1'b0},
    '{ex_pkg::ALU_SRA,  32'h8000_0000, 32'h0000_0004, 32'hf800_0000, 1'b0},
    '{ex_pkg::ALU_SLT,  32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, 1'b0},
    '{ex_pkg::ALU_SLTU, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000, 1'b0},
    '{ex_pkg::ALU_EQ,   32'h0000_1234, 32'h0000_1234, 32'h0000_0001, 1'b1},
    '{ex_pkg::ALU_NE,   32'h0000_1234, 32'h0000_1234, 32'h0000_0000, 1'b0},
    '{ex_pkg::ALU_LT,   32'h8000_0000, 32'h0000_0000, 32'h0000_0001, 1'b1},
    '{ex_pkg::ALU_GE,   32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{ex_pkg::ALU_LTU,  32'h8000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{ex_pkg::ALU_GEU,  32'h8000_0000, 32'h0000_0000, 32'h0000_0001, 1'b1}
  };

  ex_stage dut0 (.*);

  always #HALF_PERIOD clk = ~clk;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Upper word of the signed 64-bit product
  function automatic ex_pkg::word_t mulh_ref(ex_pkg::word_t a, ex_pkg::word_t b);
    longint sa;
    longint sb;
    longint p;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    p  = sa * sb;
    return p[63:32];
  endfunction

  function automatic ex_pkg::word_t dot16_ref(
    ex_pkg::word_t a,
    ex_pkg::word_t b,
    ex_pkg::word_t c
  );
    int ah;
    int al;
    int bh;
    int bl;
    ah = int'($signed(a[31:16]));
    al = int'($signed(a[15:0]));
    bh = int'($signed(b[31:16]));
    bl = int'($signed(b[15:0]));
    return c + ex_pkg::word_t'(ah * bh) + ex_pkg::word_t'(al * bl);
  endfunction

  task automatic flag_mismatch(string sig, logic [31:0] got, logic [31:0] want);
    errors++;
    $display("FAILED %s got %h expected %h at %0t", sig, got, want, $time);
  endtask

  task automatic drive_idle();
    alu_en_i            = 1'b0;
    alu_operator_i      = ex_pkg::ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_en_i           = 1'b0;
    mult_operator_i     = ex_pkg::MUL_MUL;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    mult_operand_c_i    = '0;
    lsu_en_i            = 1'b0;
    lsu_rdata_i         = '0;
    lsu_tospr_ex_i      = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    wb_ready_i          = 1'b1;
  endtask

  // Inputs stay as they are while waiting for the high word
  task automatic wait_multicycle(output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < WAIT_LIMIT && !ok; n++) begin
      @(negedge clk);
      #SAMPLE_DLY;
      ok = mult_multicycle_o;
    end
    if (!ok) begin
      timeouts++;
      $display("Timeout: mult_multicycle_o never went high after a MULH issue");
    end
  endtask

  initial begin
    ex_pkg::word_t a;
    ex_pkg::word_t b;
    ex_pkg::word_t c;
    ex_pkg::word_t word;
    ex_pkg::word_t mark;
    bit            ok;
    clk   = 1'b0;
    rst_n = 1'b0;
    drive_idle();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #SAMPLE_DLY;
    if (regfile_we_wb_o !== 1'b0) flag_mismatch("regfile_we_wb_o", regfile_we_wb_o, 0);
    if (mult_multicycle_o !== 1'b0) flag_mismatch("mult_multicycle_o", mult_multicycle_o, 0);
    if (ex_ready_o !== 1'b1) flag_mismatch("ex_ready_o", ex_ready_o, 1);

    //////////////////////////////
    // ALU table
    //////////////////////////////
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      drive_idle();
      c                   = next_random();
      alu_en_i            = 1'b1;
      alu_operator_i      = alu_tab[i].op;
      alu_operand_a_i     = alu_tab[i].a;
      alu_operand_b_i     = alu_tab[i].b;
      alu_operand_c_i     = c;
      regfile_alu_we_i    = i[0];  // Alternates so both levels are forwarded
      regfile_alu_waddr_i = 6'(i);
      #SAMPLE_DLY;
      if (regfile_alu_wdata_fw_o !== alu_tab[i].res)
        flag_mismatch("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, alu_tab[i].res);
      if (branch_decision_o !== alu_tab[i].br)
        flag_mismatch("branch_decision_o", branch_decision_o, alu_tab[i].br);
      if (jump_target_o !== c) flag_mismatch("jump_target_o", jump_target_o, c);
      if (regfile_alu_we_fw_o !== i[0])
        flag_mismatch("regfile_alu_we_fw_o", regfile_alu_we_fw_o, i[0]);
      if (regfile_alu_waddr_fw_o !== 6'(i))
        flag_mismatch("regfile_alu_waddr_fw_o", regfile_alu_waddr_fw_o, i);
      if (ex_valid_o !== 1'b1) flag_mismatch("ex_valid_o", ex_valid_o, 1);
    end

    //////////////////////////////
    // Multiplier, random operands
    //////////////////////////////
    for (int i = 0; i < NUM_RAND; i++) begin
      @(negedge clk);
      drive_idle();
      a                = next_random();
      b                = next_random();
      mult_en_i        = 1'b1;
      mult_operand_a_i = a;
      mult_operand_b_i = b;
      #SAMPLE_DLY;
      if (regfile_alu_wdata_fw_o !== a * b)
        flag_mismatch("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, a * b);
      @(negedge clk);
      c                = next_random();
      mult_operator_i  = ex_pkg::MUL_DOT16;
      mult_operand_c_i = c;
      #SAMPLE_DLY;
      if (regfile_alu_wdata_fw_o !== dot16_ref(a, b, c))
        flag_mismatch("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, dot16_ref(a, b, c));
      @(negedge clk);
      mult_operator_i = ex_pkg::MUL_MULH;  // Held until ex_ready_o rises
      #SAMPLE_DLY;
      if (ex_ready_o !== 1'b0) flag_mismatch("ex_ready_o", ex_ready_o, 0);
      if (ex_valid_o !== 1'b0) flag_mismatch("ex_valid_o", ex_valid_o, 0);
      wait_multicycle(ok);
      if (ok) begin
        if (regfile_alu_wdata_fw_o !== mulh_ref(a, b))
          flag_mismatch("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, mulh_ref(a, b));
        if (ex_ready_o !== 1'b1) flag_mismatch("ex_ready_o", ex_ready_o, 1);
      end
    end

    //////////////////////////////
    // SPR load and dot operand
    //////////////////////////////
    for (int k = 0; k < ex_pkg::NUM_SPR; k++) begin
      word = next_random();
      mark = next_random();
      @(negedge clk);
      drive_idle();
      lsu_en_i           = 1'b1;
      regfile_we_i       = 1'b1;
      regfile_waddr_i    = 6'(k);
      lsu_rdata_i        = word;
      lsu_tospr_ex_i.idx = 2'(k);
      lsu_tospr_ex_i.en  = 1'b1;
      mult_operator_i    = ex_pkg::MUL_DOT16;  // b of zero leaves only the mark
      mult_operand_c_i   = mark;
      #SAMPLE_DLY;
      if (ex_valid_o !== 1'b1) flag_mismatch("ex_valid_o", ex_valid_o, 1);
      @(negedge clk);
      drive_idle();
      lsu_rdata_i = word;  // SPR write takes it at the end of WB
      #SAMPLE_DLY;
      if (regfile_we_wb_o !== 1'b1) flag_mismatch("regfile_we_wb_o", regfile_we_wb_o, 1);
      if (regfile_wdata_wb_o !== mark)
        flag_mismatch("regfile_wdata_wb_o", regfile_wdata_wb_o, mark);
      @(negedge clk);
      drive_idle();
      b                  = next_random();
      c                  = next_random();
      mult_en_i          = 1'b1;
      mult_operator_i    = ex_pkg::MUL_DOT16;
      mult_operand_a_i   = next_random();  // Replaced by the SPR
      mult_operand_b_i   = b;
      mult_operand_c_i   = c;
      lsu_tospr_ex_i.idx = 2'(k);
      lsu_tospr_ex_i.en  = 1'b1;
      #SAMPLE_DLY;
      if (regfile_alu_wdata_fw_o !== dot16_ref(word, b, c))
        flag_mismatch("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, dot16_ref(word, b, c));
    end

    //////////////////////////////
    // EX/WB port
    //////////////////////////////
    word = next_random();
    @(negedge clk);
    drive_idle();
    lsu_en_i        = 1'b1;
    regfile_we_i    = 1'b1;
    regfile_waddr_i = 6'h2a;
    lsu_rdata_i     = word;
    #SAMPLE_DLY;
    if (ex_valid_o !== 1'b1) flag_mismatch("ex_valid_o", ex_valid_o, 1);
    @(negedge clk);
    drive_idle();
    lsu_rdata_i = word;
    #SAMPLE_DLY;
    if (regfile_we_wb_o !== 1'b1) flag_mismatch("regfile_we_wb_o", regfile_we_wb_o, 1);
    if (regfile_waddr_wb_o !== 6'h2a)
      flag_mismatch("regfile_waddr_wb_o", regfile_waddr_wb_o, 6'h2a);
    if (regfile_wdata_wb_o !== word) flag_mismatch("regfile_wdata_wb_o", regfile_wdata_wb_o, word);
    @(negedge clk);
    drive_idle();
    lsu_en_i        = 1'b1;
    regfile_we_i    = 1'b1;
    regfile_waddr_i = 6'h15;
    lsu_err_i       = 1'b1;
    #SAMPLE_DLY;
    if (regfile_we_wb_o !== 1'b0) flag_mismatch("regfile_we_wb_o", regfile_we_wb_o, 0);
    @(negedge clk);
    drive_idle();
    #SAMPLE_DLY;
    if (regfile_we_wb_o !== 1'b0) flag_mismatch("regfile_we_wb_o", regfile_we_wb_o, 0);

    //////////////////////////////
    // Priorities and stalls
    //////////////////////////////
    c = next_random();
    @(negedge clk);
    drive_idle();
    csr_access_i     = 1'b1;
    csr_rdata_i      = c;
    mult_en_i        = 1'b1;
    mult_operand_a_i = next_random();
    mult_operand_b_i = next_random();
    #SAMPLE_DLY;
    if (regfile_alu_wdata_fw_o !== c)
      flag_mismatch("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, c);
    if (compute_load_vliw_o !== 1'b0)
      flag_mismatch("compute_load_vliw_o", compute_load_vliw_o, 0);
    a = next_random();
    b = next_random();
    @(negedge clk);
    drive_idle();
    alu_en_i         = 1'b1;
    alu_operand_a_i  = a;
    alu_operand_b_i  = b;
    mult_en_i        = 1'b1;
    mult_operand_a_i = next_random();
    mult_operand_b_i = next_random();
    #SAMPLE_DLY;
    if (regfile_alu_wdata_fw_o !== a + b)
      flag_mismatch("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, a + b);
    if (compute_load_vliw_o !== 1'b1)
      flag_mismatch("compute_load_vliw_o", compute_load_vliw_o, 1);
    @(negedge clk);
    drive_idle();
    alu_en_i   = 1'b1;
    wb_ready_i = 1'b0;
    #SAMPLE_DLY;
    if (ex_ready_o !== 1'b0) flag_mismatch("ex_ready_o", ex_ready_o, 0);
    if (ex_valid_o !== 1'b0) flag_mismatch("ex_valid_o", ex_valid_o, 0);
    @(negedge clk);
    drive_idle();
    alu_en_i       = 1'b1;
    lsu_ready_ex_i = 1'b0;
    #SAMPLE_DLY;
    if (ex_ready_o !== 1'b0) flag_mismatch("ex_ready_o", ex_ready_o, 0);
    if (ex_valid_o !== 1'b0) flag_mismatch("ex_valid_o", ex_valid_o, 0);
    @(negedge clk);
    branch_in_ex_i = 1'b1;  // Branch resolves despite the stall
    #SAMPLE_DLY;
    if (ex_ready_o !== 1'b1) flag_mismatch("ex_ready_o", ex_ready_o, 1);
    if (ex_valid_o !== 1'b0) flag_mismatch("ex_valid_o", ex_valid_o, 0);

    @(negedge clk);
    drive_idle();
    $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
common/ex_pkg.sv
common/issue_if.sv
hw/ex_alu.sv
hw/ex_mult.sv
hw/spr_rnn.sv
hw/ex_wb_reg.sv
hw/ex_stage.sv
testbench/tb_ex_stage.sv

//--- run.sh
#!/bin/sh
# Build and run the EX stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ex_stage -Mdir obj_dir -f list.f; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ex_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
